/* source/fan_cfg_pkg.sv */
//######################################################################
// fan controller configuration
// tree geometry, per-level adder offsets and the flat vector types
//######################################################################

package fan_cfg_pkg;

	//######################################################################
	// tree geometry
	//######################################################################

	localparam int NUM_PES    = 32;            // leaves of the tree
	localparam int LOG2_PES   = 5;             // bits per vn id
	localparam int NUM_LEVELS = 5;
	localparam int NUM_ADDERS = NUM_PES - 1;   // 31 adders

	// adders on each level, leaf side first
	localparam int ADDERS_PER_LVL [0:NUM_LEVELS-1] = '{16, 8, 4, 2, 1};

	// first adder index of each level in the flat add / cmd vectors
	localparam int ADD_OFFSET [0:NUM_LEVELS-1] = '{0, 16, 24, 28, 30};

	localparam int IN_LATENCY = 2;   // input to decode, in cycles

	//######################################################################
	// vector types
	//######################################################################

	typedef logic [LOG2_PES-1:0] vn_id_t;

	// leaf i lives at bits i*LOG2_PES upward
	typedef logic [NUM_PES*LOG2_PES-1:0] vn_vec_t;

	typedef logic [NUM_ADDERS-1:0] add_vec_t;     // one enable per adder
	typedef logic [3*NUM_ADDERS-1:0] cmd_vec_t;   // three bits per adder
	typedef logic [19:0] sel_vec_t;               // forwarding mux selects, levels 2 to 4

endpackage

/* source/fan_cmd_pkg.sv */
//######################################################################
// fan command encoding
// adder command codes and forwarding select layout per level
//######################################################################

package fan_cmd_pkg;

	typedef logic [2:0] cmd_t;

	// which vn results are finished at a node
	localparam cmd_t CMD_NONE       = 3'b000;
	localparam cmd_t CMD_LEFT_DONE  = 3'b011;
	localparam cmd_t CMD_RIGHT_DONE = 3'b100;
	localparam cmd_t CMD_BOTH_DONE  = 3'b101;

	//######################################################################
	// forwarding select layout
	//######################################################################

	// select bits per side of one adder, zero where no muxes exist
	localparam int SEL_SIDE_W [0:fan_cfg_pkg::NUM_LEVELS-1] = '{0, 0, 1, 2, 2};

	// first select bit of each level
	localparam int SEL_OFFSET [0:fan_cfg_pkg::NUM_LEVELS-1] = '{0, 0, 0, 8, 16};

	// level 2 takes 4x2x1, level 3 2x2x2, level 4 1x2x2
	localparam int SEL_BITS = 20;

endpackage

/* source/fan_input_stage.sv */
//######################################################################
// fan input stage
// delays the vn vector to the decoders and pipelines the
// streaming-valid qualifier out to the reduction valid
//######################################################################

module fan_input_stage (
	input  logic                 clk,
	input  logic                 rst,
	input  fan_cfg_pkg::vn_vec_t i_vn,
	input  logic                 i_stationary,
	input  logic                 i_data_valid,
	output fan_cfg_pkg::vn_vec_t o_vn,
	output logic                 o_dec_valid,
	output logic                 o_reduction_valid
);

	// two more stages past decode, matching the level 0 skew
	localparam int VALID_STAGES = fan_cfg_pkg::IN_LATENCY + 2;

	fan_cfg_pkg::vn_vec_t r_vn [fan_cfg_pkg::IN_LATENCY];
	logic [VALID_STAGES-1:0] r_valid;

	// vn delay line
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < fan_cfg_pkg::IN_LATENCY; i++) begin
				r_vn[i] <= '0;
			end
		end else begin
			r_vn[0] <= i_vn;
			for (int i = 1; i < fan_cfg_pkg::IN_LATENCY; i++) begin
				r_vn[i] <= r_vn[i-1];
			end
		end
	end

	// first stage holds the streaming qualifier
	always_ff @(posedge clk) begin
		if (rst) begin
			r_valid <= '0;
		end else begin
			r_valid <= {r_valid[VALID_STAGES-2:0], i_data_valid & ~i_stationary};
		end
	end

	assign o_vn              = r_vn[fan_cfg_pkg::IN_LATENCY-1];
	assign o_dec_valid       = r_valid[fan_cfg_pkg::IN_LATENCY-1];   // lines up with o_vn
	assign o_reduction_valid = r_valid[VALID_STAGES-1];

endmodule

/* source/fan_level_decode.sv */
//######################################################################
// fan level decode
// add enable, completion command and forwarding selects for every
// adder of one tree level, purely combinational
//######################################################################

module fan_level_decode #(
	parameter int LEVEL = 0,
	localparam int N = fan_cfg_pkg::ADDERS_PER_LVL[LEVEL],
	localparam int SW = fan_cmd_pkg::SEL_SIDE_W[LEVEL],
	localparam int SEL_W = (SW > 0) ? 2 * N * SW : 1
) (
	input  fan_cfg_pkg::vn_vec_t i_vn,
	input  logic                 i_valid,
	output logic [N-1:0]         o_add,
	output logic [3*N-1:0]       o_cmd,
	output logic [SEL_W-1:0]     o_sel
);

	localparam int HALF = 2 ** LEVEL;                          // leaves per child
	localparam int HH   = (LEVEL > 0) ? 2 ** (LEVEL - 1) : 0;  // half of a child

	fan_cfg_pkg::vn_id_t leaf [fan_cfg_pkg::NUM_PES];

	// eq_b[k] high when leaf k-1 and leaf k carry the same vn
	// bit 0 and the top bit are the tree edges, always a boundary
	logic [fan_cfg_pkg::NUM_PES:0] eq_b;

	// true when eq_b[first] .. eq_b[first+len-1] are all set, len 0 gives 1
	function automatic logic all_same(
		input logic [fan_cfg_pkg::NUM_PES:0] eq,
		input int                            first,
		input int                            len
	);
		logic r;
		r = 1'b1;
		for (int i = 0; i <= fan_cfg_pkg::NUM_PES; i++) begin
			if (i >= first && i < first + len) begin
				r = r & eq[i];
			end
		end
		return r;
	endfunction

	always_comb begin
		for (int i = 0; i < fan_cfg_pkg::NUM_PES; i++) begin
			leaf[i] = i_vn[i*fan_cfg_pkg::LOG2_PES +: fan_cfg_pkg::LOG2_PES];
		end
	end

	always_comb begin
		eq_b = '0;
		for (int i = 1; i < fan_cfg_pkg::NUM_PES; i++) begin
			eq_b[i] = (leaf[i-1] == leaf[i]);
		end
	end

	//######################################################################
	// per adder decode
	//######################################################################

	for (genvar x = 0; x < N; x++) begin : g_adder
		localparam int LO = x * 2 * HALF;        // first leaf covered
		localparam int M  = LO + HALF;           // first leaf of right child
		localparam int HI = LO + 2 * HALF - 1;   // last leaf covered

		logic add;
		logic left_done;
		logic right_done;
		fan_cmd_pkg::cmd_t cmd;

		always_comb begin
			add = i_valid & eq_b[M];
			// vn stops at m-1, starts inside this subtree and was not finished lower down
			left_done = !eq_b[M] && !all_same(eq_b, LO, HALF) && all_same(eq_b, M - HH, HH);
			right_done = !eq_b[M] && !all_same(eq_b, M + 1, HALF) && all_same(eq_b, M + 1, HH);

			if (!i_valid) begin
				cmd = fan_cmd_pkg::CMD_NONE;
			end else if (left_done && right_done) begin
				cmd = fan_cmd_pkg::CMD_BOTH_DONE;
			end else if (left_done) begin
				cmd = fan_cmd_pkg::CMD_LEFT_DONE;
			end else if (right_done) begin
				cmd = fan_cmd_pkg::CMD_RIGHT_DONE;
			end else begin
				cmd = fan_cmd_pkg::CMD_NONE;
			end
		end

		assign o_add[x]        = add;
		assign o_cmd[3*x +: 3] = cmd;

		if (SW > 0) begin : g_sel
			logic [SW-1:0] sel_l;
			logic [SW-1:0] sel_r;

			always_comb begin
				int j_l;
				int j_r;
				// level of the lowest common ancestor, grows with the run length
				j_l = 0;
				j_r = 0;
				for (int k = 1; k < LEVEL; k++) begin
					if (all_same(eq_b, M - 2 ** k, 2 ** k)) begin
						j_l = k;
					end
					if (all_same(eq_b, M + 1, 2 ** k)) begin
						j_r = k;
					end
				end

				if (!i_valid) begin
					sel_l = '0;
					sel_r = '0;
				end else if (SW == 1) begin
					sel_l = SW'(LEVEL - 1 - j_l);   // 1-bit muxes count from the outside
					sel_r = SW'(j_r);
				end else begin
					sel_l = SW'(j_l);
					sel_r = SW'(LEVEL - 1 - j_r);
				end
			end

			assign o_sel[2*SW*x +: 2*SW] = {sel_r, sel_l};   // left side in the low bits
		end
	end

	// no forwarding muxes on levels 0 and 1
	if (SW == 0) begin : g_no_sel
		assign o_sel = '0;
	end

endmodule

/* source/level_skew.sv */
//######################################################################
// level skew
// diagonal delay line for one level's control fields, the last
// stage is the output register
//######################################################################

module level_skew #(
	parameter int DEPTH = 2,
	parameter int WIDTH = 1
) (
	input  logic             clk,
	input  logic             rst,
	input  logic [WIDTH-1:0] i_fields,
	output logic [WIDTH-1:0] o_fields
);

	logic [WIDTH-1:0] r_stage [DEPTH];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				r_stage[i] <= '0;
			end
		end else begin
			r_stage[0] <= i_fields;
			for (int i = 1; i < DEPTH; i++) begin
				r_stage[i] <= r_stage[i-1];
			end
		end
	end

	assign o_fields = r_stage[DEPTH-1];   // output register

endmodule

/* source/fan_ctrl_top.sv */
//######################################################################
// fan controller top
// input stage, one decoder and one skew line per tree level
//######################################################################

module fan_ctrl_top (
	input  logic                  clk,
	input  logic                  rst,
	input  fan_cfg_pkg::vn_vec_t  i_vn,
	input  logic                  i_stationary,
	input  logic                  i_data_valid,
	output fan_cfg_pkg::add_vec_t o_reduction_add,
	output fan_cfg_pkg::cmd_vec_t o_reduction_cmd,
	output fan_cfg_pkg::sel_vec_t o_reduction_sel,
	output logic                  o_reduction_valid
);

	fan_cfg_pkg::vn_vec_t w_vn;
	logic w_dec_valid;
	logic [fan_cmd_pkg::SEL_BITS-1:0] w_sel;   // gathered from levels 2 to 4

	fan_input_stage u_input_stage (
		.clk               (clk),
		.rst               (rst),
		.i_vn              (i_vn),
		.i_stationary      (i_stationary),
		.i_data_valid      (i_data_valid),
		.o_vn              (w_vn),
		.o_dec_valid       (w_dec_valid),
		.o_reduction_valid (o_reduction_valid)
	);

	//######################################################################
	// per level decode and diagonal skew
	//######################################################################

	for (genvar l = 0; l < fan_cfg_pkg::NUM_LEVELS; l++) begin : g_level
		localparam int N     = fan_cfg_pkg::ADDERS_PER_LVL[l];
		localparam int A_OFF = fan_cfg_pkg::ADD_OFFSET[l];
		localparam int SW    = fan_cmd_pkg::SEL_SIDE_W[l];
		localparam int SEL_W = 2 * N * SW;
		localparam int S_OFF = fan_cmd_pkg::SEL_OFFSET[l];

		logic [N-1:0]   dec_add;
		logic [N-1:0]   skw_add;
		logic [3*N-1:0] dec_cmd;
		logic [3*N-1:0] skw_cmd;

		if (SW > 0) begin : g_with_sel
			logic [SEL_W-1:0] dec_sel;
			logic [SEL_W-1:0] skw_sel;

			fan_level_decode #(.LEVEL(l)) u_decode (
				.i_vn    (w_vn),
				.i_valid (w_dec_valid),
				.o_add   (dec_add),
				.o_cmd   (dec_cmd),
				.o_sel   (dec_sel)
			);

			// one extra stage per level, so level l lags level l-1 by a cycle
			level_skew #(.DEPTH(l + 2), .WIDTH(4 * N + SEL_W)) u_skew (
				.clk      (clk),
				.rst      (rst),
				.i_fields ({dec_sel, dec_cmd, dec_add}),
				.o_fields ({skw_sel, skw_cmd, skw_add})
			);

			assign w_sel[S_OFF +: SEL_W] = skw_sel;
		end else begin : g_no_sel
			fan_level_decode #(.LEVEL(l)) u_decode (
				.i_vn    (w_vn),
				.i_valid (w_dec_valid),
				.o_add   (dec_add),
				.o_cmd   (dec_cmd),
				.o_sel   ()
			);

			level_skew #(.DEPTH(l + 2), .WIDTH(4 * N)) u_skew (
				.clk      (clk),
				.rst      (rst),
				.i_fields ({dec_cmd, dec_add}),
				.o_fields ({skw_cmd, skw_add})
			);
		end

		assign o_reduction_add[A_OFF +: N]       = skw_add;
		assign o_reduction_cmd[3*A_OFF +: 3*N]   = skw_cmd;
	end

	assign o_reduction_sel = w_sel;

endmodule

/* bench/fan_ctrl_tb.sv */
//######################################################################
// fan controller testbench
// replays the vector file through the controller and checks every
// level's fields at its diagonal skew slot
//######################################################################

module fan_ctrl_tb;

	localparam int MAX_VEC  = 64;
	localparam int MAX_EDGE = 2048;

	logic                  clk = 1'b0;
	logic                  rst;
	fan_cfg_pkg::vn_vec_t  i_vn;
	logic                  i_stationary;
	logic                  i_data_valid;
	fan_cfg_pkg::add_vec_t o_reduction_add;
	fan_cfg_pkg::cmd_vec_t o_reduction_cmd;
	fan_cfg_pkg::sel_vec_t o_reduction_sel;
	logic                  o_reduction_valid;

	// vectors as read from the file
	fan_cfg_pkg::vn_vec_t  vec_vn    [MAX_VEC];
	logic                  vec_stat  [MAX_VEC];
	logic                  vec_valid [MAX_VEC];
	fan_cfg_pkg::add_vec_t vec_add   [MAX_VEC];
	fan_cfg_pkg::cmd_vec_t vec_cmd   [MAX_VEC];
	fan_cfg_pkg::sel_vec_t vec_sel   [MAX_VEC];
	int num_vec;

	// expectation per sampling edge, index 0 and untouched edges stay zero
	fan_cfg_pkg::add_vec_t exp_add  [MAX_EDGE];
	fan_cfg_pkg::cmd_vec_t exp_cmd  [MAX_EDGE];
	fan_cfg_pkg::sel_vec_t exp_sel  [MAX_EDGE];
	logic                  exp_qual [MAX_EDGE];
	int                    exp_id   [MAX_EDGE];   // -1 for idle cycles
	logic                  test_bad [2*MAX_VEC];

	int     edge_cnt;
	int     err_count;
	int     tests_run;
	int     tests_failed;
	int     gap;
	integer seed;

	fan_ctrl_top u_fan_ctrl_top (
		.clk               (clk),
		.rst               (rst),
		.i_vn              (i_vn),
		.i_stationary      (i_stationary),
		.i_data_valid      (i_data_valid),
		.o_reduction_add   (o_reduction_add),
		.o_reduction_cmd   (o_reduction_cmd),
		.o_reduction_sel   (o_reduction_sel),
		.o_reduction_valid (o_reduction_valid)
	);

	always #5 clk = ~clk;

	always @(posedge clk) edge_cnt = edge_cnt + 1;

	task automatic load_vectors();
		int fd;
		int n;
		string line;
		fd = $fopen("bench/fan_vectors.txt", "r");
		num_vec = 0;
		if (fd == 0) begin
			$display("could not open the vector file bench/fan_vectors.txt");
			return;
		end
		while (!$feof(fd) && num_vec < MAX_VEC) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 1 && line.getc(0) != "/") begin
				n = $sscanf(line, "%h %h %h %h %h %h", vec_vn[num_vec], vec_stat[num_vec],
					vec_valid[num_vec], vec_add[num_vec], vec_cmd[num_vec], vec_sel[num_vec]);
				if (n == 6) num_vec++;
			end
		end
		$fclose(fd);
	endtask

	// one input cycle, recorded against the edge that samples it
	task automatic drive_cycle(input int k, input int id);
		@(negedge clk);
		if (k < 0) begin
			i_vn         = '0;
			i_stationary = 1'b0;
			i_data_valid = 1'b0;
		end else begin
			i_vn                   = vec_vn[k];
			i_stationary           = vec_stat[k];
			i_data_valid           = vec_valid[k];
			exp_add[edge_cnt + 1]  = vec_add[k];
			exp_cmd[edge_cnt + 1]  = vec_cmd[k];
			exp_sel[edge_cnt + 1]  = vec_sel[k];
			exp_qual[edge_cnt + 1] = vec_valid[k] & ~vec_stat[k];
		end
		exp_id[edge_cnt + 1] = id;
	endtask

	task automatic report_mismatch(input string what, input int lvl, input int e,
			input logic [95:0] got, input logic [95:0] want);
		$display("ERROR at time %0t: level %0d %s got %h expected %h", $time, lvl, what, got, want);
		err_count++;
		if (e >= 1 && exp_id[e] >= 0) test_bad[exp_id[e]] = 1'b1;
	endtask

	//######################################################################
	// checks, level l of the vector sampled at edge e shows after e+3+l
	//######################################################################

	always @(negedge clk) begin
		int e;
		fan_cfg_pkg::add_vec_t am;
		fan_cfg_pkg::cmd_vec_t cm;
		fan_cfg_pkg::sel_vec_t sm;
		for (int l = 0; l < fan_cfg_pkg::NUM_LEVELS; l++) begin
			e = edge_cnt - 3 - l;
			if (e < 1 || e >= MAX_EDGE) e = 0;
			am = '0;
			cm = '0;
			sm = '0;
			for (int i = 0; i < fan_cfg_pkg::ADDERS_PER_LVL[l]; i++) begin
				am[fan_cfg_pkg::ADD_OFFSET[l] + i] = 1'b1;
				cm[3*(fan_cfg_pkg::ADD_OFFSET[l] + i) +: 3] = 3'b111;
			end
			for (int i = 0; i < 2*fan_cfg_pkg::ADDERS_PER_LVL[l]*fan_cmd_pkg::SEL_SIDE_W[l]; i++)
				sm[fan_cmd_pkg::SEL_OFFSET[l] + i] = 1'b1;
			if ((o_reduction_add & am) !== (exp_add[e] & am))
				report_mismatch("add", l, e, o_reduction_add & am, exp_add[e] & am);
			if ((o_reduction_cmd & cm) !== (exp_cmd[e] & cm))
				report_mismatch("cmd", l, e, o_reduction_cmd & cm, exp_cmd[e] & cm);
			if ((o_reduction_sel & sm) !== (exp_sel[e] & sm))
				report_mismatch("sel", l, e, o_reduction_sel & sm, exp_sel[e] & sm);
		end
		e = edge_cnt - 3;
		if (e < 1 || e >= MAX_EDGE) e = 0;
		if (o_reduction_valid !== exp_qual[e])
			report_mismatch("valid", 0, e, o_reduction_valid, exp_qual[e]);
		// root level done, so this vector is finished
		e = edge_cnt - 7;
		if (e >= 1 && e < MAX_EDGE && exp_id[e] >= 0) begin
			tests_run++;
			if (test_bad[exp_id[e]]) tests_failed++;
			$display("test %0d (vector %0d): %s", exp_id[e], exp_id[e] % num_vec,
				test_bad[exp_id[e]] ? "mismatch" : "ok");
		end
	end

	// watchdog sized from the vector count
	initial begin
		#1;
		#((num_vec + 20) * 10 * 10);
		$display("timeout: the run did not finish in the expected time");
		$display("Verification failed");
		$finish;
	end

	initial begin
		seed         = 22752;
		edge_cnt     = 0;
		err_count    = 0;
		tests_run    = 0;
		tests_failed = 0;
		rst          = 1'b1;
		i_vn         = '0;
		i_stationary = 1'b0;
		i_data_valid = 1'b0;
		for (int i = 0; i < MAX_EDGE; i++) begin
			exp_add[i]  = '0;
			exp_cmd[i]  = '0;
			exp_sel[i]  = '0;
			exp_qual[i] = 1'b0;
			exp_id[i]   = -1;
		end
		for (int i = 0; i < 2*MAX_VEC; i++) test_bad[i] = 1'b0;
		load_vectors();
		if (num_vec == 0) begin
			$display("no vectors could be read");
			$display("Verification failed");
			$finish;
		end else begin
			repeat (5) @(posedge clk);
			@(negedge clk);
			rst = 1'b0;
			// first pass with random idle gaps, second back to back
			for (int p = 0; p < 2; p++) begin
				for (int k = 0; k < num_vec; k++) begin
					gap = (p == 0) ? $unsigned($random(seed)) % 3 : 0;
					repeat (gap) drive_cycle(-1, -1);
					drive_cycle(k, p * num_vec + k);
				end
			end
			repeat (12) drive_cycle(-1, -1);
			@(negedge clk);
			$display("tests run %0d, tests failed %0d, mismatches %0d",
				tests_run, tests_failed, err_count);
			if (err_count == 0 && tests_failed == 0 && tests_run == 2 * num_vec) begin
				$display("Verification passed");
			end else begin
				$display("Verification failed");
			end
			$finish;
		end
	end

endmodule

/* bench/fan_vectors.txt */
// columns: i_vn (160 bit hex, leaf i at bits 5i) i_stationary i_data_valid
//          expected add (31 bit) cmd (93 bit) sel (20 bit), all hex
// all leaves in one vn
0000000000000000000000000000000000000000 0 1 7fffffff 000000000000000000000000 322aa
// all ids distinct
ffbbcdeb38bdab49ca307b9ac5a928398a418820 0 1 00000000 000000000000b6db6db6db6d c8855
// runs of two leaves
7bdce6b58c5ad4a4a50839cc62948418c4208400 0 1 0000ffff 000000b6db6d000000000000 c8855
// two halves, each a whole subtree
0842108421084210842100000000000000000000 0 1 3fffffff 140000000000000000000000 322aa
// single-leaf vn at leaf 0
0000000000000000000000000000000000000001 0 1 7ffffffe 000000000000000000000003 322aa
// leaves 0 to 3 in one vn
0000000000000000000000000000000000008421 0 1 7effffff 000003000000000000000000 321aa
// stationary data
ffbbcdeb38bdab49ca307b9ac5a928398a418820 1 1 00000000 000000000000000000000000 00000
// data not valid
7bdce6b58c5ad4a4a50839cc62948418c4208400 0 0 00000000 000000000000000000000000 00000

/* build.f */
source/fan_cfg_pkg.sv
source/fan_cmd_pkg.sv
source/fan_input_stage.sv
source/fan_level_decode.sv
source/level_skew.sv
source/fan_ctrl_top.sv
bench/fan_ctrl_tb.sv

/* Bender.yml */
package:
  name: fan_ctrl

sources:
  - source/fan_cfg_pkg.sv
  - source/fan_cmd_pkg.sv
  - source/fan_input_stage.sv
  - source/fan_level_decode.sv
  - source/level_skew.sv
  - source/fan_ctrl_top.sv
  - target: test
    files:
      - bench/fan_ctrl_tb.sv
